//--- design/simd_dec_config.svh
`ifndef SIMD_DEC_CONFIG_SVH
`define SIMD_DEC_CONFIG_SVH

// namespace operand fields
`define SIMD_NS_ID_W 3
`define SIMD_NS_INDEX_W 5

// instruction word layout
`define SIMD_OPCODE_W 4
`define SIMD_FN_W 4
`define SIMD_INST_W 32
// immediate of the control view, everything below opcode and fn
`define SIMD_IMM_W (`SIMD_INST_W - `SIMD_OPCODE_W - `SIMD_FN_W)

// instruction memory and group buffer
`define SIMD_IMEM_ADDR_W 10
`define SIMD_GROUP_ID_W 4

// single-level loop iteration count
`define SIMD_LOOP_CNT_W 12

`endif

//--- design/simd_dec_pkg.sv
`include "simd_dec_config.svh"

package simd_dec_pkg;

	// opcodes the sequencer reacts to, all others are compute
	typedef enum logic [`SIMD_OPCODE_W-1:0] {
		OP_LD_ST   = 4'd5,
		OP_LOOP    = 4'd7,
		OP_PERMUTE = 4'd8,
		OP_SYNC    = 4'd10
	} opcode_e;

	// function codes
	localparam logic [`SIMD_FN_W-1:0] FN_LOOP_CFG = 4'd1;
	localparam logic [`SIMD_FN_W-1:0] FN_LOOP_START = 4'd2;
	localparam logic [`SIMD_FN_W-1:0] FN_LD_START = 4'd5;
	localparam logic [`SIMD_FN_W-1:0] FN_ST_START = 4'd13;
	localparam logic [`SIMD_FN_W-1:0] FN_PERMUTE_START = 4'd3;
	// sync ends the group when fn[3:1] matches this
	localparam logic [`SIMD_FN_W-2:0] FN_GROUP_END_HI = 3'b110;

	typedef struct packed {
		logic [`SIMD_NS_ID_W-1:0]    ns_id;
		logic [`SIMD_NS_INDEX_W-1:0] ns_index;
	} ns_operand_t;

	// operand view of an instruction
	typedef struct packed {
		logic [`SIMD_OPCODE_W-1:0] opcode;
		logic [`SIMD_FN_W-1:0]     fn;
		ns_operand_t               dest;
		ns_operand_t               src1;
		ns_operand_t               src2;
	} inst_fields_t;

	// control view, loop instructions carry an immediate
	typedef struct packed {
		logic [`SIMD_OPCODE_W-1:0] opcode;
		logic [`SIMD_FN_W-1:0]     fn;
		logic [`SIMD_IMM_W-1:0]    imm;
	} inst_ctrl_t;

	typedef union packed {
		inst_fields_t fields;
		inst_ctrl_t   ctrl;
	} inst_word_u;

	typedef struct packed {
		logic [`SIMD_OPCODE_W-1:0] opcode;
		logic [`SIMD_FN_W-1:0]     fn;
		ns_operand_t               dest;
		ns_operand_t               src1;
		ns_operand_t               src2;
	} dec_inst_t;

	typedef enum logic [2:0] {
		CLS_COMPUTE,
		CLS_LOOP_CFG,
		CLS_LOOP_START,
		CLS_LD,
		CLS_ST,
		CLS_PERMUTE,
		CLS_GROUP_END
	} inst_class_e;

endpackage

//--- design/inst_field_decode.sv
`timescale 1ns/1ps
`include "simd_dec_config.svh"

module inst_field_decode
	import simd_dec_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  inst_word_u             inst_word,
	input  logic                   inst_valid,
	output dec_inst_t              dec_inst,
	output logic                   dec_valid,
	output inst_class_e            inst_class,
	output logic [`SIMD_IMM_W-1:0] loop_imm
);

	inst_word_u word_q;
	logic [`SIMD_OPCODE_W-1:0] opcode;
	logic [`SIMD_FN_W-1:0] fn;

	// capture on the memory's return pulse only
	always_ff @(posedge clk) begin
		if (inst_valid) begin
			word_q <= inst_word;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= inst_valid;
		end
	end

	assign opcode = word_q.fields.opcode;
	assign fn = word_q.fields.fn;

	// operand view
	always_comb begin
		dec_inst.opcode = opcode;
		dec_inst.fn = fn;
		dec_inst.dest = word_q.fields.dest;
		dec_inst.src1 = word_q.fields.src1;
		dec_inst.src2 = word_q.fields.src2;
	end

	// control view, only meaningful for loop instructions
	assign loop_imm = word_q.ctrl.imm;

	always_comb begin
		inst_class = CLS_COMPUTE;
		if (opcode == OP_LOOP) begin
			if (fn == FN_LOOP_CFG) begin
				inst_class = CLS_LOOP_CFG;
			end else if (fn == FN_LOOP_START) begin
				inst_class = CLS_LOOP_START;
			end
		end else if (opcode == OP_LD_ST) begin
			if (fn == FN_LD_START) begin
				inst_class = CLS_LD;
			end else if (fn == FN_ST_START) begin
				inst_class = CLS_ST;
			end
		end else if (opcode == OP_PERMUTE && fn == FN_PERMUTE_START) begin
			inst_class = CLS_PERMUTE;
		end else if (opcode == OP_SYNC && fn[`SIMD_FN_W-1:1] == FN_GROUP_END_HI) begin
			inst_class = CLS_GROUP_END;
		end
	end

endmodule

//--- design/loop_ctrl.sv
`timescale 1ns/1ps
`include "simd_dec_config.svh"

module loop_ctrl (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         loop_cfg_load,
	input  logic                         loop_arm,
	input  logic                         step,
	input  logic [`SIMD_IMEM_ADDR_W-1:0] pc,
	input  logic [`SIMD_IMM_W-1:0]       loop_imm,
	output logic [`SIMD_IMEM_ADDR_W-1:0] next_pc,
	output logic                         in_loop,
	output logic [`SIMD_LOOP_CNT_W-1:0]  iteration
);

	logic [`SIMD_LOOP_CNT_W-1:0] loop_n;
	logic [`SIMD_LOOP_CNT_W-1:0] iter_cnt;
	logic [`SIMD_LOOP_CNT_W-1:0] cfg_n;
	logic [`SIMD_IMEM_ADDR_W-1:0] body_len;
	logic [`SIMD_IMEM_ADDR_W-1:0] body_start;
	logic [`SIMD_IMEM_ADDR_W-1:0] body_end;
	logic at_body_end;
	logic last_pass;

	assign cfg_n = loop_imm[`SIMD_LOOP_CNT_W-1:0];
	assign body_len = loop_imm[`SIMD_IMEM_ADDR_W-1:0];
	assign at_body_end = in_loop && (pc == body_end);
	assign last_pass = (iter_cnt == loop_n);

	// iteration count, zero is taken as a single pass
	always_ff @(posedge clk) begin
		if (reset) begin
			loop_n <= `SIMD_LOOP_CNT_W'(1);
		end else if (loop_cfg_load) begin
			loop_n <= (cfg_n == '0) ? `SIMD_LOOP_CNT_W'(1) : cfg_n;
		end
	end

	// body bounds relative to the loop-start address
	always_ff @(posedge clk) begin
		if (loop_arm) begin
			body_start <= pc + 1'b1;
			body_end <= pc + body_len;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			in_loop <= 1'b0;
			iter_cnt <= '0;
		end else if (loop_arm) begin
			// empty body just falls through
			in_loop <= (body_len != '0);
			iter_cnt <= `SIMD_LOOP_CNT_W'(1);
		end else if (step && at_body_end) begin
			if (last_pass) begin
				in_loop <= 1'b0;
			end else begin
				iter_cnt <= iter_cnt + 1'b1;
			end
		end
	end

	// jump back unless this was the last pass
	assign next_pc = (at_body_end && !last_pass) ? body_start : pc + 1'b1;

	assign iteration = in_loop ? iter_cnt : '0;

endmodule

//--- design/inst_seq_fsm.sv
`timescale 1ns/1ps
`include "simd_dec_config.svh"

module inst_seq_fsm
	import simd_dec_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,
	input  logic [`SIMD_GROUP_ID_W-1:0]  group_id,
	input  logic [`SIMD_IMEM_ADDR_W-1:0] grp_rd_data,
	input  logic                         grp_rd_valid,
	input  logic                         dec_valid,
	input  inst_class_e                  inst_class,
	input  logic [`SIMD_IMEM_ADDR_W-1:0] next_pc,
	input  logic                         ld_done,
	input  logic                         st_done,
	input  logic                         shuffle_done,
	output logic                         grp_rd_req,
	output logic [`SIMD_GROUP_ID_W-1:0]  grp_rd_addr,
	output logic                         imem_rd_req,
	output logic [`SIMD_IMEM_ADDR_W-1:0] imem_rd_addr,
	output logic [`SIMD_IMEM_ADDR_W-1:0] pc,
	output logic                         loop_cfg_load,
	output logic                         loop_arm,
	output logic                         step,
	output logic                         ready,
	output logic                         stall,
	output logic                         in_ld_st,
	output logic                         in_shuffle,
	output logic                         done
);

	typedef enum logic [2:0] {
		IDLE,
		GROUP_ADDR,
		FETCH,
		WAIT_INST,
		WAIT_LD,
		WAIT_ST,
		WAIT_PERMUTE
	} state_e;

	state_e state;
	state_e state_d;
	logic [`SIMD_IMEM_ADDR_W-1:0] pc_d;
	logic finish;
	logic unit_done;

	// a done pulse only counts in its own wait state
	always_comb begin
		case (state)
			WAIT_LD: unit_done = ld_done;
			WAIT_ST: unit_done = st_done;
			WAIT_PERMUTE: unit_done = shuffle_done;
			default: unit_done = 1'b0;
		endcase
	end

	always_comb begin
		state_d = state;
		pc_d = pc;
		step = 1'b0;
		loop_cfg_load = 1'b0;
		loop_arm = 1'b0;
		finish = 1'b0;
		case (state)
			IDLE: begin
				if (start) begin
					state_d = GROUP_ADDR;
				end
			end
			GROUP_ADDR: begin
				if (grp_rd_valid) begin
					pc_d = grp_rd_data;
					state_d = FETCH;
				end
			end
			FETCH: begin
				state_d = WAIT_INST;
			end
			WAIT_INST: begin
				if (dec_valid) begin
					case (inst_class)
						CLS_LD: state_d = WAIT_LD;
						CLS_ST: state_d = WAIT_ST;
						CLS_PERMUTE: state_d = WAIT_PERMUTE;
						CLS_GROUP_END: begin
							finish = 1'b1;
							state_d = IDLE;
						end
						default: begin
							// compute and loop instructions move straight on
							loop_cfg_load = (inst_class == CLS_LOOP_CFG);
							loop_arm = (inst_class == CLS_LOOP_START);
							step = 1'b1;
							pc_d = next_pc;
							state_d = FETCH;
						end
					endcase
				end
			end
			WAIT_LD, WAIT_ST, WAIT_PERMUTE: begin
				if (unit_done) begin
					step = 1'b1;
					pc_d = next_pc;
					state_d = FETCH;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			pc <= '0;
			done <= 1'b0;
		end else begin
			state <= state_d;
			pc <= pc_d;
			done <= finish;
		end
	end

	// group number held for the whole lookup
	always_ff @(posedge clk) begin
		if (ready && start) begin
			grp_rd_addr <= group_id;
		end
	end

	assign grp_rd_req = (state == GROUP_ADDR);
	assign imem_rd_req = (state == FETCH);
	assign imem_rd_addr = pc;

	assign ready = (state == IDLE);
	assign stall = state inside {WAIT_LD, WAIT_ST, WAIT_PERMUTE};
	assign in_ld_st = (state == WAIT_LD) || (state == WAIT_ST);
	assign in_shuffle = (state == WAIT_PERMUTE);

endmodule

//--- design/simd_inst_decoder.sv
`timescale 1ns/1ps
`include "simd_dec_config.svh"

module simd_inst_decoder
	import simd_dec_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         start,
	input  logic [`SIMD_GROUP_ID_W-1:0]  group_id,
	input  logic [`SIMD_IMEM_ADDR_W-1:0] grp_rd_data,
	input  logic                         grp_rd_valid,
	input  logic [`SIMD_INST_W-1:0]      inst_word,
	input  logic                         inst_valid,
	input  logic                         ld_done,
	input  logic                         st_done,
	input  logic                         shuffle_done,
	output logic                         ready,
	output logic                         grp_rd_req,
	output logic [`SIMD_GROUP_ID_W-1:0]  grp_rd_addr,
	output logic                         imem_rd_req,
	output logic [`SIMD_IMEM_ADDR_W-1:0] imem_rd_addr,
	output dec_inst_t                    dec_inst,
	output logic                         dec_valid,
	output logic                         stall,
	output logic                         in_ld_st,
	output logic                         in_shuffle,
	output logic                         in_loop,
	output logic [`SIMD_LOOP_CNT_W-1:0]  iteration,
	output logic                         done
);

	inst_class_e inst_class;
	logic [`SIMD_IMM_W-1:0] loop_imm;
	logic [`SIMD_IMEM_ADDR_W-1:0] pc;
	logic [`SIMD_IMEM_ADDR_W-1:0] next_pc;
	logic loop_cfg_load;
	logic loop_arm;
	logic step;

	// raw memory word enters as the two-view union
	inst_field_decode field_decode_i (
		.clk        (clk),
		.reset      (reset),
		.inst_word  (inst_word),
		.inst_valid (inst_valid),
		.dec_inst   (dec_inst),
		.dec_valid  (dec_valid),
		.inst_class (inst_class),
		.loop_imm   (loop_imm)
	);

	loop_ctrl loop_ctrl_i (
		.clk           (clk),
		.reset         (reset),
		.loop_cfg_load (loop_cfg_load),
		.loop_arm      (loop_arm),
		.step          (step),
		.pc            (pc),
		.loop_imm      (loop_imm),
		.next_pc       (next_pc),
		.in_loop       (in_loop),
		.iteration     (iteration)
	);

	inst_seq_fsm seq_fsm_i (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.group_id      (group_id),
		.grp_rd_data   (grp_rd_data),
		.grp_rd_valid  (grp_rd_valid),
		.dec_valid     (dec_valid),
		.inst_class    (inst_class),
		.next_pc       (next_pc),
		.ld_done       (ld_done),
		.st_done       (st_done),
		.shuffle_done  (shuffle_done),
		.grp_rd_req    (grp_rd_req),
		.grp_rd_addr   (grp_rd_addr),
		.imem_rd_req   (imem_rd_req),
		.imem_rd_addr  (imem_rd_addr),
		.pc            (pc),
		.loop_cfg_load (loop_cfg_load),
		.loop_arm      (loop_arm),
		.step          (step),
		.ready         (ready),
		.stall         (stall),
		.in_ld_st      (in_ld_st),
		.in_shuffle    (in_shuffle),
		.done          (done)
	);

endmodule

//--- bench/simd_dec_assert.sv
`timescale 1ns/1ps

module simd_dec_assert (
	input logic clk,
	input logic reset,
	input logic imem_rd_req,
	input logic stall,
	input logic ready,
	input logic done
);

	int fail_count = 0;

	// single outstanding fetch, so never two request cycles in a row
	fetch_gap_a: assert property (@(posedge clk) disable iff (reset)
		imem_rd_req |=> !imem_rd_req)
		else begin
			fail_count++;
			$error("imem_rd_req high in two consecutive cycles");
		end

	no_fetch_in_stall_a: assert property (@(posedge clk) disable iff (reset)
		stall |-> !imem_rd_req)
		else begin
			fail_count++;
			$error("imem_rd_req issued while stall is high");
		end

	ready_stall_a: assert property (@(posedge clk) disable iff (reset)
		!(ready && stall))
		else begin
			fail_count++;
			$error("ready and stall high together");
		end

	done_pulse_a: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else begin
			fail_count++;
			$error("done held longer than one cycle");
		end

endmodule

bind inst_seq_fsm simd_dec_assert fsm_assert_i (
	.clk         (clk),
	.reset       (reset),
	.imem_rd_req (imem_rd_req),
	.stall       (stall),
	.ready       (ready),
	.done        (done)
);

//--- bench/simd_dec_tb.sv
`timescale 1ns/1ps
`include "simd_dec_config.svh"

module simd_dec_tb
	import simd_dec_pkg::*;
();

	// one expected decode, with its fetch address and the loop state seen next to it
	typedef struct packed {
		dec_inst_t                    inst;
		logic [`SIMD_IMEM_ADDR_W-1:0] addr;
		logic                         in_loop;
		logic [`SIMD_LOOP_CNT_W-1:0]  iteration;
	} exp_entry_t;

	logic clk;
	logic reset;
	logic start;
	logic [`SIMD_GROUP_ID_W-1:0] group_id;
	logic [`SIMD_IMEM_ADDR_W-1:0] grp_rd_data;
	logic grp_rd_valid;
	logic [`SIMD_INST_W-1:0] inst_word;
	logic inst_valid;
	logic ld_done;
	logic st_done;
	logic shuffle_done;
	logic ready;
	logic grp_rd_req;
	logic [`SIMD_GROUP_ID_W-1:0] grp_rd_addr;
	logic imem_rd_req;
	logic [`SIMD_IMEM_ADDR_W-1:0] imem_rd_addr;
	dec_inst_t dec_inst;
	logic dec_valid;
	logic stall;
	logic in_ld_st;
	logic in_shuffle;
	logic in_loop;
	logic [`SIMD_LOOP_CNT_W-1:0] iteration;
	logic done;

	logic [`SIMD_INST_W-1:0] imem [1 << `SIMD_IMEM_ADDR_W];
	logic [`SIMD_IMEM_ADDR_W-1:0] grp_mem [1 << `SIMD_GROUP_ID_W];
	exp_entry_t exp_q [$];
	logic [15:0] lfsr = 16'd31584;
	int total_expected = 0;
	int groups_done = 0;

	simd_inst_decoder simd_inst_decoder_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// fibonacci lfsr, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic inst_class_e classify_word(input logic [31:0] w);
		logic [3:0] op;
		logic [3:0] fn;
		op = w[31:28];
		fn = w[27:24];
		if (op == 4'd7 && fn == 4'd1) return CLS_LOOP_CFG;
		if (op == 4'd7 && fn == 4'd2) return CLS_LOOP_START;
		if (op == 4'd5 && fn == 4'd5) return CLS_LD;
		if (op == 4'd5 && fn == 4'd13) return CLS_ST;
		if (op == 4'd8 && fn == 4'd3) return CLS_PERMUTE;
		if (op == 4'd10 && fn[3:1] == 3'b110) return CLS_GROUP_END;
		return CLS_COMPUTE;
	endfunction

	// compute or stall word, never a loop or sync opcode
	function automatic logic [31:0] body_word();
		logic [2:0] pick;
		logic [3:0] op;
		logic [3:0] fn;
		logic [23:0] operands;
		pick = rand_bits(3);
		op = rand_bits(4);
		fn = rand_bits(4);
		operands = rand_bits(24);
		case (pick)
			3'd4: begin
				op = 4'd5;
				fn = 4'd5;
			end
			3'd5: begin
				op = 4'd5;
				fn = 4'd13;
			end
			3'd6: begin
				op = 4'd8;
				fn = 4'd3;
			end
			default: begin
				if (op == 4'd7 || op == 4'd10) op = op ^ 4'd1;
			end
		endcase
		return {op, fn, operands};
	endfunction

	function automatic void gen_program(input logic [9:0] addr);
		logic [9:0] a;
		logic [9:0] body_len;
		logic [11:0] upper;
		logic [11:0] n;
		int items;
		int k;
		int j;
		a = addr;
		items = 4 + rand_bits(3);
		for (k = 0; k < items; k++) begin
			if (rand_bits(3) == 7) begin
				// N of 0 to 3, body of 1 to 3 words
				n = rand_bits(2);
				upper = rand_bits(12);
				body_len = 1 + rand_bits(2) % 3;
				imem[a] = {4'd7, 4'd1, upper, n};
				imem[a + 1] = {4'd7, 4'd2, upper, 2'b00, body_len};
				a = a + 2;
				for (j = 0; j < body_len; j++) begin
					imem[a] = body_word();
					a = a + 1;
				end
			end else begin
				imem[a] = body_word();
				a = a + 1;
			end
		end
		upper = rand_bits(12);
		imem[a] = {4'd10, 3'b110, upper[0], 12'h000, upper};
	endfunction

	// walks the program the way the sequencer should
	function automatic void build_expected(input logic [9:0] start_addr);
		logic [9:0] pc;
		logic [9:0] body_start;
		logic [9:0] body_end;
		logic [11:0] loop_n;
		logic [11:0] iter;
		logic active;
		logic finished;
		logic [31:0] w;
		exp_entry_t e;
		inst_class_e cls;
		int i;
		pc = start_addr;
		body_start = '0;
		body_end = '0;
		loop_n = 12'd1;
		iter = '0;
		active = 1'b0;
		finished = 1'b0;
		for (i = 0; i < 4096 && !finished; i++) begin
			w = imem[pc];
			cls = classify_word(w);
			e.inst = w;
			e.addr = pc;
			e.in_loop = active;
			e.iteration = active ? iter : '0;
			exp_q.push_back(e);
			total_expected++;
			if (cls == CLS_GROUP_END) finished = 1'b1;
			if (cls == CLS_LOOP_CFG) loop_n = (w[11:0] == '0) ? 12'd1 : w[11:0];
			if (cls == CLS_LOOP_START) begin
				body_start = pc + 1;
				body_end = pc + w[9:0];
				active = (w[9:0] != '0);
				iter = 12'd1;
				pc = pc + 1;
			end else if (active && pc == body_end && iter != loop_n) begin
				iter = iter + 1;
				pc = body_start;
			end else begin
				if (active && pc == body_end) active = 1'b0;
				pc = pc + 1;
			end
		end
	endfunction

	task automatic stop_run();
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_with(input string msg);
		$display("[ERROR] %0t %s", $time, msg);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, got);
			stop_run();
		end
	endtask

	// unit model, wrong done pulses first, then the matching one
	task automatic serve_unit(input inst_class_e cls);
		int wait_cycles;
		check_value("stall", stall, 1);
		check_value("in_ld_st", in_ld_st, cls != CLS_PERMUTE);
		check_value("in_shuffle", in_shuffle, cls == CLS_PERMUTE);
		wait_cycles = rand_bits(2);
		repeat (wait_cycles) begin
			@(posedge clk);
			#1;
			check_value("imem_rd_req", imem_rd_req, 0);
		end
		ld_done = (cls != CLS_LD);
		st_done = (cls != CLS_ST);
		shuffle_done = (cls != CLS_PERMUTE);
		@(posedge clk);
		#1;
		ld_done = (cls == CLS_LD);
		st_done = (cls == CLS_ST);
		shuffle_done = (cls == CLS_PERMUTE);
		check_value("stall", stall, 1);
		check_value("imem_rd_req", imem_rd_req, 0);
		@(posedge clk);
		#1;
		ld_done = 1'b0;
		st_done = 1'b0;
		shuffle_done = 1'b0;
		check_value("stall", stall, 0);
		check_value("in_ld_st", in_ld_st, 0);
		check_value("in_shuffle", in_shuffle, 0);
		check_value("imem_rd_req", imem_rd_req, 1);
	endtask

	task automatic run_group(input int g, input logic [9:0] addr);
		int target;
		grp_mem[g] = addr;
		build_expected(addr);
		target = groups_done + 1;
		@(posedge clk);
		#1;
		check_value("ready", ready, 1);
		start = 1'b1;
		group_id = g;
		@(posedge clk);
		#1;
		start = 1'b0;
		check_value("grp_rd_req", grp_rd_req, 1);
		check_value("grp_rd_addr", grp_rd_addr, g);
		check_value("ready", ready, 0);
		wait (groups_done == target);
	endtask

	// group buffer
	initial begin
		int lat;
		forever begin
			@(posedge clk);
			#1;
			if (grp_rd_req === 1'b1) begin
				lat = 1 + rand_bits(2);
				repeat (lat - 1) begin
					@(posedge clk);
					#1;
				end
				grp_rd_data = grp_mem[grp_rd_addr];
				grp_rd_valid = 1'b1;
				@(posedge clk);
				#1;
				grp_rd_valid = 1'b0;
				check_value("imem_rd_req", imem_rd_req, 1);
			end
		end
	end

	// instruction memory
	initial begin
		int lat;
		logic [9:0] addr;
		forever begin
			@(posedge clk);
			#1;
			if (imem_rd_req === 1'b1) begin
				if (exp_q.size() == 0) begin
					fail_with("fetch issued after the program ended");
				end
				check_value("imem_rd_addr", imem_rd_addr, exp_q[0].addr);
				addr = imem_rd_addr;
				lat = 1 + rand_bits(2);
				repeat (lat - 1) begin
					@(posedge clk);
					#1;
				end
				inst_word = imem[addr];
				inst_valid = 1'b1;
				@(posedge clk);
				#1;
				inst_valid = 1'b0;
				check_value("dec_valid", dec_valid, 1);
			end
		end
	end

	// compare process
	initial begin
		exp_entry_t e;
		inst_class_e cls;
		forever begin
			@(posedge clk);
			#1;
			if (dec_valid === 1'b1) begin
				if (exp_q.size() == 0) fail_with("instruction decoded after the program ended");
				e = exp_q.pop_front();
				check_value("dec_inst", dec_inst, e.inst);
				check_value("in_loop", in_loop, e.in_loop);
				check_value("iteration", iteration, e.iteration);
				cls = classify_word(e.inst);
				@(posedge clk);
				#1;
				if (cls inside {CLS_LD, CLS_ST, CLS_PERMUTE}) begin
					serve_unit(cls);
				end else if (cls == CLS_GROUP_END) begin
					check_value("done", done, 1);
					check_value("ready", ready, 1);
					@(posedge clk);
					#1;
					check_value("done", done, 0);
					groups_done++;
				end else begin
					check_value("imem_rd_req", imem_rd_req, 1);
				end
			end
		end
	end

	// watchdog, budget grows with each program built
	initial begin
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (simd_inst_decoder_i.seq_fsm_i.fsm_assert_i.fail_count != 0) begin
				fail_with("a protocol assertion failed");
			end
			if (cycles > 200 * (total_expected + 5)) begin
				fail_with("timeout, the sequencer stopped making progress");
			end
		end
	end

	initial begin
		int a;
		int g;
		reset = 1'b1;
		start = 1'b0;
		group_id = '0;
		grp_rd_data = '0;
		grp_rd_valid = 1'b0;
		inst_word = '0;
		inst_valid = 1'b0;
		ld_done = 1'b0;
		st_done = 1'b0;
		shuffle_done = 1'b0;
		for (a = 0; a < (1 << `SIMD_IMEM_ADDR_W); a++) begin
			imem[a] = {22'h0, 10'(a)};
		end
		for (g = 0; g < (1 << `SIMD_GROUP_ID_W); g++) begin
			grp_mem[g] = {4'(g), ~4'(g), 2'b10};
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		check_value("ready", ready, 1);
		check_value("grp_rd_req", grp_rd_req, 0);
		check_value("imem_rd_req", imem_rd_req, 0);
		check_value("dec_valid", dec_valid, 0);
		check_value("stall", stall, 0);
		check_value("in_ld_st", in_ld_st, 0);
		check_value("in_shuffle", in_shuffle, 0);
		check_value("in_loop", in_loop, 0);
		check_value("done", done, 0);

		// straight compute run
		for (a = 0; a < 5; a++) begin
			imem[10'h040 + a] = 32'h1000_0000 + 32'h0011_0203 * (a + 1);
		end
		imem[10'h045] = 32'hAC00_0000;
		run_group(1, 10'h040);

		// N=3, L=2
		imem[10'h100] = 32'h3000_0001;
		imem[10'h101] = 32'h7100_0003;
		imem[10'h102] = 32'h7200_0002;
		imem[10'h103] = 32'h4123_4567;
		imem[10'h104] = 32'h6ABC_DEF0;
		imem[10'h105] = 32'h9000_0005;
		imem[10'h106] = 32'hAD00_0000;
		run_group(2, 10'h100);

		// one of each unit stall
		imem[10'h180] = 32'h1111_1111;
		imem[10'h181] = 32'h5500_0012;
		imem[10'h182] = 32'h2222_2222;
		imem[10'h183] = 32'h5D00_0034;
		imem[10'h184] = 32'h8300_0056;
		imem[10'h185] = 32'h3333_3333;
		imem[10'h186] = 32'hAC00_0000;
		run_group(3, 10'h180);

		for (g = 4; g < 10; g++) begin
			gen_program(10'h200 + 10'(64 * (g - 4)));
			run_group(g, 10'h200 + 10'(64 * (g - 4)));
		end

		repeat (4) @(posedge clk);
		#1;
		// a failure on the last edge has not reached the watchdog yet
		if (simd_inst_decoder_i.seq_fsm_i.fsm_assert_i.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+design
design/simd_dec_pkg.sv
design/inst_field_decode.sv
design/loop_ctrl.sv
design/inst_seq_fsm.sv
design/simd_inst_decoder.sv
bench/simd_dec_assert.sv
bench/simd_dec_tb.sv
